/* Makefile */
# Verilator build and run for the receive PCS testbench
# override on the command line, e.g. make SEED=12345 LOG=run.log

TOP       ?= pcs_rx_tb
SEED      ?= 3608048004
LOG       ?= sim.log
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
FILELIST  := src.f

BUILD_FLAGS := --binary --timing --assert -Wno-fatal \
               --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only -Wall --timing \
               --top-module $(TOP) -GSEED=$(SEED)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/pcs_rx_tb.sv */
// receive PCS testbench
// directed tests with a scrambler and 64b/66b encoder model on the line side,
// an XGMII scoreboard with latency check, and a watchdog

`timescale 1ns/100ps

module pcs_rx_tb import pcs_line_pkg::*, xgmii_pkg::*; #(
    parameter logic [31:0] SEED = 32'hd70e7184
);

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DLY    = 10;      // after rising edge
    localparam int RESET_CYCLES = 8;
    localparam int PIPE_LAT     = 4;       // header strobe to xgmii valid
    localparam int DRAIN_LIMIT  = 20;
    // lock 67 blocks, data 20, decode 11, errors 3 and loss of lock at most 143
    localparam int TOTAL_BLOCKS = 67 + 20 + 11 + 3 + 143;
    localparam int WD_CYCLES    = RESET_CYCLES + 2 * TOTAL_BLOCKS + 300;

    localparam xgmii_data_t IDLE_RXD = {XGMII_LANES{XGMII_IDLE}};
    localparam xgmii_data_t ERR_RXD  = {XGMII_LANES{XGMII_ERROR}};

    logic        rx_user_clk;
    logic        rx_user_rst;
    word_t       rx_data_i;
    sync_hdr_t   rx_header_i;
    logic        rx_header_vld_i;
    logic        rx_slip_o;
    logic        rx_block_lock_o;
    xgmii_data_t xgmii_rxd_o;
    xgmii_ctrl_t xgmii_rxc_o;
    logic        xgmii_rxd_vld_o;
    logic        decode_error_o;

    // scoreboard with one entry per block sent
    xgmii_data_t exp_rxd_q[$];
    xgmii_ctrl_t exp_rxc_q[$];
    bit          exp_err_q[$];
    bit          exp_chk_q[$];         // value check skipped on the first block
    int          exp_cyc_q[$];         // cycle of header strobe

    logic [SCR_LEN-1:0] scr_st = '0;   // [0] newest line bit
    int    cyc = 0;
    int    slip_cnt = 0;
    int    mismatch_cnt = 0;
    int    other_err_cnt = 0;
    bit    first_blk = 1'b1;
    bit    lock_track = 1'b0;          // count blocks once locked
    int    since_lock = 0;
    string cur_test = "none";

    pcs_rx_top dut_i (
        .rx_user_clk     (rx_user_clk),
        .rx_user_rst     (rx_user_rst),
        .rx_data_i       (rx_data_i),
        .rx_header_i     (rx_header_i),
        .rx_header_vld_i (rx_header_vld_i),
        .rx_slip_o       (rx_slip_o),
        .rx_block_lock_o (rx_block_lock_o),
        .xgmii_rxd_o     (xgmii_rxd_o),
        .xgmii_rxc_o     (xgmii_rxc_o),
        .xgmii_rxd_vld_o (xgmii_rxd_vld_o),
        .decode_error_o  (decode_error_o)
    );

    initial rx_user_clk = 1'b0;
    always #(CLK_PERIOD / 2) rx_user_clk = ~rx_user_clk;

    always @(posedge rx_user_clk) cyc <= cyc + 1;

    // ------------------------------
    // line side model
    // ------------------------------
    function automatic logic [7:0] term_type(input int k);
        case (k)
            0: term_type = BT_TERM0;
            1: term_type = BT_TERM1;
            2: term_type = BT_TERM2;
            3: term_type = BT_TERM3;
            4: term_type = BT_TERM4;
            5: term_type = BT_TERM5;
            6: term_type = BT_TERM6;
            default: term_type = BT_TERM7;
        endcase
    endfunction

    function automatic block_t rand_block();
        rand_block = {$urandom, $urandom};
    endfunction

    // xgmii lanes to header and payload for the kept block types
    task automatic encode_xgmii(input xgmii_data_t rxd, input xgmii_ctrl_t rxc,
                                output sync_hdr_t hdr, output block_t blk);
        int  k;
        int  j;
        bit  found;
        found = 1'b0;
        blk   = '0;
        hdr   = HDR_CTRL;
        if (rxc == 8'h00) begin
            hdr = HDR_DATA;
            blk = rxd;
        end else if (rxc == 8'hff && rxd == IDLE_RXD) begin
            blk[7:0] = BT_IDLE;             // idle codes are all zero
        end else if (rxc == 8'h01 && rxd[7:0] == XGMII_START) begin
            blk = {rxd[63:8], BT_START};
        end else begin
            for (k = 0; k < XGMII_LANES; k++) begin
                if (!found && rxc == (8'hff << k) && rxd[8*k +: 8] == XGMII_TERM) begin
                    found    = 1'b1;
                    blk[7:0] = term_type(k);
                    for (j = 0; j < k; j++) begin
                        blk[8*j+8 +: 8] = rxd[8*j +: 8];   // data lanes after type byte
                    end
                end
            end
            assert (found) else begin
                other_err_cnt++;
                $display("%s: encoder model has no block type for rxc %h", cur_test, rxc);
            end
        end
    endtask

    // serial scrambler 1 + x^39 + x^58 taking bit 0 first
    task automatic scramble_block(input block_t din, output block_t dout);
        int   i;
        logic b;
        for (i = 0; i < BLOCK_W; i++) begin
            b       = din[i] ^ scr_st[SCR_TAP_A-1] ^ scr_st[SCR_TAP_B-1];
            dout[i] = b;
            scr_st  = {scr_st[SCR_LEN-2:0], b};
        end
    endtask

    // one block as two words with the low half first
    task automatic send_block(input sync_hdr_t hdr, input block_t payload,
                              input xgmii_data_t erxd, input xgmii_ctrl_t erxc,
                              input bit eerr);
        block_t line;
        scramble_block(payload, line);
        @(posedge rx_user_clk);
        #DRIVE_DLY;
        rx_data_i       = line[31:0];
        rx_header_i     = hdr;
        rx_header_vld_i = 1'b1;
        exp_rxd_q.push_back(erxd);
        exp_rxc_q.push_back(erxc);
        exp_err_q.push_back(eerr);
        exp_chk_q.push_back(!first_blk);   // descrambler still filling
        exp_cyc_q.push_back(cyc);
        first_blk = 1'b0;
        @(posedge rx_user_clk);
        #DRIVE_DLY;
        rx_data_i       = line[63:32];
        rx_header_vld_i = 1'b0;
        if (lock_track) begin
            since_lock++;
        end
    endtask

    task automatic send_xgmii(input xgmii_data_t rxd, input xgmii_ctrl_t rxc);
        sync_hdr_t hdr;
        block_t    blk;
        encode_xgmii(rxd, rxc, hdr, blk);
        send_block(hdr, blk, rxd, rxc, 1'b0);  // decodes back to the same lanes
    endtask

    task automatic send_bad_hdr();
        sync_hdr_t hdr;
        hdr = ($urandom & 1) ? 2'b11 : 2'b00;
        send_block(hdr, rand_block(), ERR_RXD, 8'hff, 1'b1);
    endtask

    // ------------------------------
    // scoreboard
    // ------------------------------
    task automatic check_block();
        xgmii_data_t e_rxd;
        xgmii_ctrl_t e_rxc;
        bit          e_err;
        bit          e_chk;
        int          e_cyc;
        assert (exp_rxd_q.size() != 0) else begin
            other_err_cnt++;
            $display("%s: output block with nothing expected", cur_test);
        end
        if (exp_rxd_q.size() != 0) begin
            e_rxd = exp_rxd_q.pop_front();
            e_rxc = exp_rxc_q.pop_front();
            e_err = exp_err_q.pop_front();
            e_chk = exp_chk_q.pop_front();
            e_cyc = exp_cyc_q.pop_front();
            assert (cyc - e_cyc == PIPE_LAT) else begin
                mismatch_cnt++;
                $display("Mismatch %s latency: expected %0d, actual %0d",
                         cur_test, PIPE_LAT, cyc - e_cyc);
            end
            if (e_chk) begin
                assert (xgmii_rxd_o == e_rxd) else begin
                    mismatch_cnt++;
                    $display("Mismatch %s rxd: expected %h, actual %h",
                             cur_test, e_rxd, xgmii_rxd_o);
                end
                assert (xgmii_rxc_o == e_rxc) else begin
                    mismatch_cnt++;
                    $display("Mismatch %s rxc: expected %h, actual %h",
                             cur_test, e_rxc, xgmii_rxc_o);
                end
                assert (decode_error_o == e_err) else begin
                    mismatch_cnt++;
                    $display("Mismatch %s decode_error: expected %0b, actual %0b",
                             cur_test, e_err, decode_error_o);
                end
            end
        end
    endtask

    // sample mid cycle away from both edges
    always @(negedge rx_user_clk) begin
        if (!rx_user_rst) begin
            if (rx_slip_o) slip_cnt++;
            if (xgmii_rxd_vld_o) begin
                check_block();
            end else begin
                assert (!decode_error_o) else begin
                    other_err_cnt++;
                    $display("%s: decode_error_o high without a valid block", cur_test);
                end
            end
        end
    end

    // wait for every expected block to come out
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_rxd_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge rx_user_clk);
            n++;
        end
        assert (exp_rxd_q.size() == 0) else begin
            other_err_cnt++;
            $display("%s: %0d blocks never came out", cur_test, exp_rxd_q.size());
        end
        @(negedge rx_user_clk);
    endtask

    task automatic check_lock(input bit exp_lock);
        assert (rx_block_lock_o == exp_lock) else begin
            mismatch_cnt++;
            $display("Mismatch %s block_lock: expected %0b, actual %0b",
                     cur_test, exp_lock, rx_block_lock_o);
        end
    endtask

    task automatic check_slips(input int start, input int exp_n);
        assert (slip_cnt - start == exp_n) else begin
            mismatch_cnt++;
            $display("Mismatch %s slip pulses: expected %0d, actual %0d",
                     cur_test, exp_n, slip_cnt - start);
        end
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic check_reset_state();
        int n;
        cur_test = "reset_state";
        for (n = 0; n < 12; n++) begin
            @(negedge rx_user_clk);
            assert (!rx_slip_o && !rx_block_lock_o && !xgmii_rxd_vld_o && !decode_error_o)
            else begin
                mismatch_cnt++;
                $display("Mismatch %s slip/lock/vld/err: expected 0000, actual %b%b%b%b",
                         cur_test, rx_slip_o, rx_block_lock_o, xgmii_rxd_vld_o,
                         decode_error_o);
            end
        end
    endtask

    task automatic acquire_lock();
        int s0;
        int n;
        cur_test = "lock_acquisition";
        s0 = slip_cnt;
        repeat (3) send_bad_hdr();
        for (n = 0; n < LOCK_GOOD_CNT - 1; n++) send_xgmii(IDLE_RXD, 8'hff);
        wait_drain();
        check_lock(1'b0);                  // one short
        check_slips(s0, 3);
        send_xgmii(IDLE_RXD, 8'hff);
        wait_drain();
        check_lock(1'b1);
        lock_track = 1'b1;
        since_lock = 0;
    endtask

    task automatic run_data_path();
        cur_test = "data_path";
        repeat (20) send_xgmii(rand_block(), 8'h00);
        wait_drain();
    endtask

    task automatic run_frame_decode();
        xgmii_data_t rnd;
        xgmii_data_t lanes;
        int          k;
        int          i;
        cur_test = "frame_decode";
        send_xgmii(IDLE_RXD, 8'hff);
        rnd = rand_block();
        send_xgmii({rnd[63:8], XGMII_START}, 8'h01);
        send_xgmii(rand_block(), 8'h00);
        for (k = 0; k < XGMII_LANES; k++) begin
            rnd = rand_block();
            for (i = 0; i < XGMII_LANES; i++) begin
                if (i < k) lanes[8*i +: 8] = rnd[8*i +: 8];
                else if (i == k) lanes[8*i +: 8] = XGMII_TERM;
                else lanes[8*i +: 8] = XGMII_IDLE;
            end
            send_xgmii(lanes, 8'hff << k);
        end
        wait_drain();
    endtask

    task automatic run_error_blocks();
        block_t blk;
        cur_test = "error_substitution";
        send_bad_hdr();
        blk      = rand_block();
        blk[7:0] = 8'h4b;                  // ordered set type is not supported
        send_block(HDR_CTRL, blk, ERR_RXD, 8'hff, 1'b1);
        // idle type with one code that is not idle
        blk                        = '0;
        blk[7:0]                   = BT_IDLE;
        blk[8+CC_W*3 +: CC_W]      = 7'h1e;
        send_block(HDR_CTRL, blk, ERR_RXD, 8'hff, 1'b1);
        wait_drain();
    endtask

    task automatic lose_lock();
        int s0;
        cur_test = "loss_of_lock";
        while (since_lock % LOCK_WINDOW != 0) send_xgmii(IDLE_RXD, 8'hff);
        s0 = slip_cnt;
        repeat (UNLOCK_BAD_CNT - 1) send_bad_hdr();
        repeat (LOCK_WINDOW - UNLOCK_BAD_CNT + 1) send_xgmii(IDLE_RXD, 8'hff);
        wait_drain();
        check_lock(1'b1);                  // 15 bad in one window
        check_slips(s0, 0);
        repeat (UNLOCK_BAD_CNT) send_bad_hdr();
        wait_drain();
        check_lock(1'b0);
        check_slips(s0, 1);
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        int unused_seed;
        unused_seed     = $urandom(SEED);
        rx_user_rst     = 1'b1;
        rx_data_i       = '0;
        rx_header_i     = HDR_DATA;
        rx_header_vld_i = 1'b0;
        repeat (RESET_CYCLES) @(posedge rx_user_clk);
        #DRIVE_DLY;
        rx_user_rst = 1'b0;

        check_reset_state();
        acquire_lock();
        run_data_path();
        run_frame_decode();
        run_error_blocks();
        lose_lock();

        $display("mismatches: %0d, other errors: %0d", mismatch_cnt, other_err_cnt);
        if (mismatch_cnt == 0 && other_err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("%s: watchdog ran out after %0d cycles", cur_test, WD_CYCLES);
        $display("mismatches: %0d, other errors: %0d", mismatch_cnt, other_err_cnt + 1);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* src.f */
verilog/pcs_line_pkg.sv
verilog/xgmii_pkg.sv
verilog/rx_block_assembler.sv
verilog/rx_block_lock.sv
verilog/rx_descrambler.sv
verilog/rx_block_decoder.sv
verilog/pcs_rx_top.sv
bench/pcs_rx_tb.sv

/* verilog/pcs_line_pkg.sv */
// 64b/66b line coding definitions
// sync headers, block type codes, block lock thresholds and scrambler taps
// shared by the receive PCS blocks

package pcs_line_pkg;

    // ------------------------------
    // widths and basic types
    // ------------------------------
    localparam int WORD_W  = 32;            // transceiver word
    localparam int BLOCK_W = 64;            // block payload, no header

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [BLOCK_W-1:0] block_t;    // byte 0 low, bit 0 first on the line
    typedef logic [1:0]         sync_hdr_t;

    // sync headers, 00 and 11 are invalid
    localparam sync_hdr_t HDR_DATA = 2'b01;
    localparam sync_hdr_t HDR_CTRL = 2'b10;

    // ------------------------------
    // block type field, byte 0 of a control block
    // ------------------------------
    localparam logic [7:0] BT_IDLE  = 8'h1e;    // all control, idle
    localparam logic [7:0] BT_START = 8'h78;    // start in lane 0
    localparam logic [7:0] BT_TERM0 = 8'h87;
    localparam logic [7:0] BT_TERM1 = 8'h99;
    localparam logic [7:0] BT_TERM2 = 8'haa;
    localparam logic [7:0] BT_TERM3 = 8'hb4;
    localparam logic [7:0] BT_TERM4 = 8'hcc;
    localparam logic [7:0] BT_TERM5 = 8'hd2;
    localparam logic [7:0] BT_TERM6 = 8'he1;
    localparam logic [7:0] BT_TERM7 = 8'hff;

    // block lock
    localparam int LOCK_GOOD_CNT  = 64;     // good headers in a row to lock
    localparam int UNLOCK_BAD_CNT = 16;     // bad headers per window to unlock
    localparam int LOCK_WINDOW    = 64;     // window length in blocks
    localparam int LOCK_CNT_W     = $clog2(LOCK_WINDOW + 1);
    typedef logic [LOCK_CNT_W-1:0] lock_cnt_t;

    // self-synchronous scrambler, 1 + x^39 + x^58
    localparam int SCR_LEN   = 58;
    localparam int SCR_TAP_A = 39;
    localparam int SCR_TAP_B = 58;

endpackage

/* verilog/pcs_rx_top.sv */
// receive PCS top
// transceiver words in, XGMII out, through assembler, descrambler and
// decoder, with block lock driving the gearbox slip

`timescale 1ns/100ps

module pcs_rx_top import pcs_line_pkg::*, xgmii_pkg::*; (
    input  logic         rx_user_clk,
    input  logic         rx_user_rst,       // already synchronous

    input  word_t        rx_data_i,
    input  sync_hdr_t    rx_header_i,
    input  logic         rx_header_vld_i,

    output logic         rx_slip_o,
    output logic         rx_block_lock_o,

    output xgmii_data_t  xgmii_rxd_o,
    output xgmii_ctrl_t  xgmii_rxc_o,
    output logic         xgmii_rxd_vld_o,   // 4 cycles after header strobe
    output logic         decode_error_o
);

    // ------------------------------
    // internal pipeline
    // ------------------------------
    block_t    blk_data;
    sync_hdr_t blk_hdr;
    logic      blk_vld;
    block_t    dsc_data;
    sync_hdr_t dsc_hdr;
    logic      dsc_vld;

    rx_block_assembler u_assembler (
        .rx_user_clk (rx_user_clk),
        .rx_user_rst (rx_user_rst),
        .word_i      (rx_data_i),
        .hdr_i       (rx_header_i),
        .hdr_vld_i   (rx_header_vld_i),
        .blk_data_o  (blk_data),
        .blk_hdr_o   (blk_hdr),
        .blk_vld_o   (blk_vld)
    );

    rx_block_lock u_lock (
        .rx_user_clk  (rx_user_clk),
        .rx_user_rst  (rx_user_rst),
        .blk_hdr_i    (blk_hdr),
        .blk_vld_i    (blk_vld),
        .slip_o       (rx_slip_o),
        .block_lock_o (rx_block_lock_o)
    );

    rx_descrambler u_descrambler (
        .rx_user_clk (rx_user_clk),
        .rx_user_rst (rx_user_rst),
        .blk_data_i  (blk_data),
        .blk_hdr_i   (blk_hdr),
        .blk_vld_i   (blk_vld),
        .dsc_data_o  (dsc_data),
        .dsc_hdr_o   (dsc_hdr),
        .dsc_vld_o   (dsc_vld)
    );

    // output not gated by lock
    rx_block_decoder u_decoder (
        .rx_user_clk     (rx_user_clk),
        .rx_user_rst     (rx_user_rst),
        .dsc_data_i      (dsc_data),
        .dsc_hdr_i       (dsc_hdr),
        .dsc_vld_i       (dsc_vld),
        .xgmii_rxd_o     (xgmii_rxd_o),
        .xgmii_rxc_o     (xgmii_rxc_o),
        .xgmii_rxd_vld_o (xgmii_rxd_vld_o),
        .decode_error_o  (decode_error_o)
    );

endmodule

/* verilog/rx_block_assembler.sv */
// receive block assembler
// collects two 32-bit transceiver words into one 64-bit block and
// keeps the sync header that came with the first word

`timescale 1ns/100ps

module rx_block_assembler import pcs_line_pkg::*; (
    input  logic       rx_user_clk,
    input  logic       rx_user_rst,

    input  word_t      word_i,          // one word per clock
    input  sync_hdr_t  hdr_i,
    input  logic       hdr_vld_i,       // marks first word of a block

    output block_t     blk_data_o,
    output sync_hdr_t  blk_hdr_o,
    output logic       blk_vld_o        // one cycle, after second word
);

    logic hdr_vld_d1;                   // high while second word is on word_i

    // ------------------------------
    // payload shift, no reset
    // ------------------------------
    // new word enters the top half, so the first word lands in the low half
    always_ff @(posedge rx_user_clk) begin
        blk_data_o <= {word_i, blk_data_o[BLOCK_W-1:WORD_W]};
        if (hdr_vld_i) begin
            blk_hdr_o <= hdr_i;         // held until next block starts
        end
    end

    // ------------------------------
    // strobes
    // ------------------------------
    always_ff @(posedge rx_user_clk) begin
        if (rx_user_rst) begin
            hdr_vld_d1 <= 1'b0;
            blk_vld_o  <= 1'b0;
        end else begin
            hdr_vld_d1 <= hdr_vld_i;
            blk_vld_o  <= hdr_vld_d1;   // both halves in place
        end
    end

    // gearbox gives one header per two words
    a_hdr_spacing : assert property (
        @(posedge rx_user_clk) disable iff (rx_user_rst)
        hdr_vld_i |=> !hdr_vld_i
    ) else $error("rx_block_assembler: header strobe on consecutive cycles");

endmodule

/* verilog/rx_block_decoder.sv */
// 64b/66b block decoder
// maps data, idle, start and terminate blocks onto XGMII lanes,
// anything else becomes error characters with a decode error pulse

`timescale 1ns/100ps

module rx_block_decoder import pcs_line_pkg::*, xgmii_pkg::*; (
    input  logic         rx_user_clk,
    input  logic         rx_user_rst,

    input  block_t       dsc_data_i,
    input  sync_hdr_t    dsc_hdr_i,
    input  logic         dsc_vld_i,

    output xgmii_data_t  xgmii_rxd_o,
    output xgmii_ctrl_t  xgmii_rxc_o,
    output logic         xgmii_rxd_vld_o,
    output logic         decode_error_o   // lines up with xgmii_rxd_vld_o
);

    logic [7:0]   blk_type;
    block_t       data_sh;              // payload moved down by the type byte
    logic         idle_ok;              // all eight codes are idle
    logic         term_hit;
    logic [2:0]   term_lane;            // lane of the terminate char
    xgmii_data_t  rxd_next;
    xgmii_ctrl_t  rxc_next;
    logic         err_next;

    assign blk_type = dsc_data_i[7:0];
    assign data_sh  = {8'h00, dsc_data_i[BLOCK_W-1:8]};

    always_comb begin
        idle_ok = 1'b1;
        for (int j = 0; j < XGMII_LANES; j++) begin
            if (dsc_data_i[8+CC_W*j +: CC_W] != CC_IDLE) begin
                idle_ok = 1'b0;
            end
        end
    end

    // ------------------------------
    // decode
    // ------------------------------
    always_comb begin
        rxd_next  = {XGMII_LANES{XGMII_ERROR}};  // default is error
        rxc_next  = '1;
        err_next  = 1'b1;
        term_hit  = 1'b0;
        term_lane = 3'd0;

        if (dsc_hdr_i == HDR_DATA) begin
            rxd_next = dsc_data_i;              // straight data
            rxc_next = '0;
            err_next = 1'b0;
        end else if (dsc_hdr_i == HDR_CTRL) begin
            case (blk_type)
                BT_IDLE: begin
                    if (idle_ok) begin
                        rxd_next = {XGMII_LANES{XGMII_IDLE}};
                        err_next = 1'b0;
                    end
                end
                BT_START: begin
                    rxd_next = {dsc_data_i[BLOCK_W-1:8], XGMII_START};
                    rxc_next = 8'h01;           // only lane 0 is control
                    err_next = 1'b0;
                end
                BT_TERM0: begin term_hit = 1'b1; term_lane = 3'd0; end
                BT_TERM1: begin term_hit = 1'b1; term_lane = 3'd1; end
                BT_TERM2: begin term_hit = 1'b1; term_lane = 3'd2; end
                BT_TERM3: begin term_hit = 1'b1; term_lane = 3'd3; end
                BT_TERM4: begin term_hit = 1'b1; term_lane = 3'd4; end
                BT_TERM5: begin term_hit = 1'b1; term_lane = 3'd5; end
                BT_TERM6: begin term_hit = 1'b1; term_lane = 3'd6; end
                BT_TERM7: begin term_hit = 1'b1; term_lane = 3'd7; end
                default: ;                      // unsupported type, stays error
            endcase
        end

        // terminate: data below, T at term_lane, idle above
        if (term_hit) begin
            err_next = 1'b0;
            rxc_next = 8'hff << term_lane;
            for (int i = 0; i < XGMII_LANES; i++) begin
                if (i < term_lane) begin
                    rxd_next[8*i +: 8] = data_sh[8*i +: 8];
                end else if (i == term_lane) begin
                    rxd_next[8*i +: 8] = XGMII_TERM;
                end else begin
                    rxd_next[8*i +: 8] = XGMII_IDLE;
                end
            end
        end
    end

    // ------------------------------
    // output registers
    // ------------------------------
    always_ff @(posedge rx_user_clk) begin
        if (dsc_vld_i) begin
            xgmii_rxd_o <= rxd_next;
            xgmii_rxc_o <= rxc_next;
        end
    end

    always_ff @(posedge rx_user_clk) begin
        if (rx_user_rst) begin
            xgmii_rxd_vld_o <= 1'b0;
            decode_error_o  <= 1'b0;
        end else begin
            xgmii_rxd_vld_o <= dsc_vld_i;
            decode_error_o  <= dsc_vld_i & err_next;
        end
    end

endmodule

/* verilog/rx_block_lock.sv */
// block lock FSM
// hunts for header alignment with slip pulses, locks after a run of good
// headers and drops lock on too many bad headers inside one window

`timescale 1ns/100ps

module rx_block_lock import pcs_line_pkg::*; (
    input  logic       rx_user_clk,
    input  logic       rx_user_rst,

    input  sync_hdr_t  blk_hdr_i,
    input  logic       blk_vld_i,

    output logic       slip_o,          // one cycle, to gearbox
    output logic       block_lock_o
);

    lock_cnt_t good_cnt;                // good headers in a row, unlocked
    lock_cnt_t blk_cnt;                 // blocks seen in current window
    lock_cnt_t bad_cnt;                 // bad headers in current window
    logic      hdr_ok;

    assign hdr_ok = (blk_hdr_i == HDR_DATA) || (blk_hdr_i == HDR_CTRL);

    always_ff @(posedge rx_user_clk) begin
        if (rx_user_rst) begin
            block_lock_o <= 1'b0;
            slip_o       <= 1'b0;
            good_cnt     <= '0;
            blk_cnt      <= '0;
            bad_cnt      <= '0;
        end else begin
            slip_o <= 1'b0;             // pulse by default
            if (blk_vld_i) begin
                if (!block_lock_o) begin
                    // ------------------------------
                    // hunting
                    // ------------------------------
                    if (!hdr_ok) begin
                        good_cnt <= '0;
                        slip_o   <= 1'b1;   // try next bit position
                    end else if (good_cnt == lock_cnt_t'(LOCK_GOOD_CNT - 1)) begin
                        block_lock_o <= 1'b1;
                        good_cnt     <= '0;
                        blk_cnt      <= '0;
                        bad_cnt      <= '0;
                    end else begin
                        good_cnt <= good_cnt + 1'b1;
                    end
                end else begin
                    // ------------------------------
                    // locked, windowed bad count
                    // ------------------------------
                    if (!hdr_ok && bad_cnt == lock_cnt_t'(UNLOCK_BAD_CNT - 1)) begin
                        block_lock_o <= 1'b0;   // back to hunting
                        slip_o       <= 1'b1;
                        blk_cnt      <= '0;
                        bad_cnt      <= '0;
                    end else if (blk_cnt == lock_cnt_t'(LOCK_WINDOW - 1)) begin
                        blk_cnt <= '0;          // window over, start again
                        bad_cnt <= '0;
                    end else begin
                        blk_cnt <= blk_cnt + 1'b1;
                        bad_cnt <= bad_cnt + lock_cnt_t'(!hdr_ok);
                    end
                end
            end
        end
    end

    // slip only ever asked for while hunting or on the way out of lock
    a_no_slip_locked : assert property (
        @(posedge rx_user_clk) disable iff (rx_user_rst)
        !(slip_o && block_lock_o)
    ) else $error("rx_block_lock: slip while locked");

endmodule

/* verilog/rx_descrambler.sv */
// self-synchronous descrambler, 1 + x^39 + x^58
// works on the 64 payload bits in line order, header passes through

`timescale 1ns/100ps

module rx_descrambler import pcs_line_pkg::*; (
    input  logic       rx_user_clk,
    input  logic       rx_user_rst,

    input  block_t     blk_data_i,
    input  sync_hdr_t  blk_hdr_i,
    input  logic       blk_vld_i,

    output block_t     dsc_data_o,
    output sync_hdr_t  dsc_hdr_o,
    output logic       dsc_vld_o
);

    logic [SCR_LEN-1:0]         scr_q;      // last 58 received bits, [SCR_LEN-1] newest
    logic [SCR_LEN+BLOCK_W-1:0] rx_ext;     // history followed by this block
    block_t                     dsc_next;

    // received bit i sits at rx_ext[SCR_LEN+i]
    assign rx_ext = {blk_data_i, scr_q};

    // ------------------------------
    // bitwise descramble, bit 0 first
    // ------------------------------
    always_comb begin
        for (int i = 0; i < BLOCK_W; i++) begin
            dsc_next[i] = rx_ext[SCR_LEN+i]
                        ^ rx_ext[SCR_LEN+i-SCR_TAP_A]   // 39 bits back
                        ^ rx_ext[SCR_LEN+i-SCR_TAP_B];  // 58 bits back
        end
    end

    // state tracks scrambled line bits, only on real blocks
    always_ff @(posedge rx_user_clk) begin
        if (rx_user_rst) begin
            scr_q     <= '0;
            dsc_vld_o <= 1'b0;
        end else begin
            dsc_vld_o <= blk_vld_i;
            if (blk_vld_i) begin
                scr_q <= rx_ext[SCR_LEN+BLOCK_W-1 -: SCR_LEN];
            end
        end
    end

    // payload and header registers
    always_ff @(posedge rx_user_clk) begin
        if (blk_vld_i) begin
            dsc_data_o <= dsc_next;
            dsc_hdr_o  <= blk_hdr_i;    // header is never scrambled
        end
    end

endmodule

/* verilog/xgmii_pkg.sv */
// XGMII definitions
// 64-bit data path of eight byte lanes, one control flag per lane,
// control characters and the idle code used inside control blocks

package xgmii_pkg;

    // ------------------------------
    // lane layout
    // ------------------------------
    localparam int XGMII_LANES  = 8;
    localparam int XGMII_LANE_W = 8;

    typedef logic [XGMII_LANES*XGMII_LANE_W-1:0] xgmii_data_t;  // lane i at [8i+7:8i]
    typedef logic [XGMII_LANES-1:0]              xgmii_ctrl_t;  // 1 = control char

    // ------------------------------
    // control characters
    // ------------------------------
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // 7-bit control code as carried in a 66-bit control block
    localparam int CC_W = 7;
    localparam logic [CC_W-1:0] CC_IDLE = 7'h00;

endpackage
